// ==== source/datapathPkg.sv ====
package datapathPkg;

	// Word on the shared bus and in every 32-bit register.
	typedef logic [31:0] wordT;

	// Full product held in Z, high half first.
	typedef logic [63:0] dwordT;

	// Number of one of the sixteen general registers.
	typedef logic [3:0] regIndexT;

	// Width of the immediate constant at the bottom of IR.
	localparam int constWidth = 19;

	// ALU operations. The encodings match the instruction opcode field.
	typedef enum logic [4:0] {
		opAdd  = 5'd3,
		opSub  = 5'd4,
		opShr  = 5'd5,
		opShra = 5'd6,
		opShl  = 5'd7,
		opRor  = 5'd8,
		opRol  = 5'd9,
		opAnd  = 5'd10,
		opOr   = 5'd11,
		opMul  = 5'd15,
		opNeg  = 5'd17,
		opNot  = 5'd18
	} aluOpT;

	// Which unit drives the bus this cycle.
	typedef enum logic [4:0] {
		srcNone,
		srcReg0, srcReg1, srcReg2, srcReg3,
		srcReg4, srcReg5, srcReg6, srcReg7,
		srcReg8, srcReg9, srcReg10, srcReg11,
		srcReg12, srcReg13, srcReg14, srcReg15,
		srcHi,
		srcLo,
		srcZHigh,
		srcZLow,
		srcPc,
		srcMdr,
		srcInport,
		srcC
	} busSourceT;

endpackage

// ==== source/busIf.sv ====
`timescale 1ns/1ps

interface busIf;

	datapathPkg::wordT busData;	// The shared bus itself.
	datapathPkg::wordT regData;	// General register picked by regOut.
	datapathPkg::wordT mdrData;
	datapathPkg::wordT pcData;
	datapathPkg::wordT irData;
	datapathPkg::wordT hiData;
	datapathPkg::wordT loData;
	datapathPkg::wordT inportData;
	datapathPkg::wordT cData;	// Sign-extended constant from IR.
	datapathPkg::wordT zHigh;
	datapathPkg::wordT zLow;

	modport mux (
		input regData, mdrData, pcData, hiData, loData, inportData, cData, zHigh, zLow,
		output busData
	);
	modport regs (input busData, output regData);
	modport memory (input busData, output mdrData);
	modport special (input busData, output pcData, irData, hiData, loData, inportData, cData);
	modport alu (input busData, output zHigh, zLow);

endinterface

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic Clock,
	input logic rstN,
	input logic clear,
	input logic [15:0] regIn,
	input logic [15:0] regOut,
	busIf.regs bus
);

	datapathPkg::wordT regs [16];
	datapathPkg::regIndexT outIndex;

	// More than one load strobe may be high; each selected register takes the bus.
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (clear) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 16; i++) begin
				if (regIn[i]) begin
					regs[i] <= bus.busData;
				end
			end
		end
	end

	// The out strobes are one-hot, so the highest set bit is the only one.
	always_comb begin
		outIndex = '0;
		for (int i = 0; i < 16; i++) begin
			if (regOut[i]) begin
				outIndex = datapathPkg::regIndexT'(i);
			end
		end
	end

	assign bus.regData = regs[outIndex];	// The mux only passes this on when a strobe is high.

endmodule

// ==== source/memoryRegs.sv ====
`timescale 1ns/1ps

module memoryRegs (
	input logic Clock,
	input logic rstN,
	input logic clear,
	input logic read,
	input logic mdrIn,
	input logic marIn,
	input datapathPkg::wordT memDataIn,
	output datapathPkg::wordT marAddr,
	busIf.memory bus
);

	datapathPkg::wordT mdr;
	datapathPkg::wordT mar;
	datapathPkg::wordT mdrNext;

	// MDR takes memory data during a read and the bus otherwise.
	assign mdrNext = read ? memDataIn : bus.busData;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			mdr <= '0;
			mar <= '0;
		end else if (clear) begin
			mdr <= '0;
			mar <= '0;
		end else begin
			if (mdrIn) begin
				mdr <= mdrNext;
			end
			if (marIn) begin
				mar <= bus.busData;
			end
		end
	end

	assign bus.mdrData = mdr;
	assign marAddr = mar;

endmodule

// ==== source/specialRegs.sv ====
`timescale 1ns/1ps

module specialRegs (
	input logic Clock,
	input logic rstN,
	input logic clear,
	input logic pcIn,
	input logic irIn,
	input logic hiIn,
	input logic loIn,
	input logic inportLoad,
	input datapathPkg::wordT inportIn,
	busIf.special bus
);

	localparam int extWidth = $bits(datapathPkg::wordT) - datapathPkg::constWidth;

	datapathPkg::wordT pc;
	datapathPkg::wordT ir;
	datapathPkg::wordT hi;
	datapathPkg::wordT lo;
	datapathPkg::wordT inport;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
			hi <= '0;
			lo <= '0;
			inport <= '0;
		end else if (clear) begin
			pc <= '0;
			ir <= '0;
			hi <= '0;
			lo <= '0;
			inport <= '0;
		end else begin
			if (pcIn) pc <= bus.busData;
			if (irIn) ir <= bus.busData;
			if (hiIn) hi <= bus.busData;
			if (loIn) lo <= bus.busData;
			if (inportLoad) inport <= inportIn;	// The input port samples the pins, not the bus.
		end
	end

	assign bus.pcData = pc;
	assign bus.irData = ir;
	assign bus.hiData = hi;
	assign bus.loData = lo;
	assign bus.inportData = inport;

	// Immediate field sits in the bottom bits of the instruction.
	assign bus.cData = {{extWidth{bus.irData[datapathPkg::constWidth-1]}},
		bus.irData[datapathPkg::constWidth-1:0]};

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
	input logic Clock,
	input logic rstN,
	input logic clear,
	input logic yIn,
	input logic zIn,
	input logic incPc,
	input datapathPkg::aluOpT opcode,
	busIf.alu bus
);

	datapathPkg::wordT y;
	datapathPkg::wordT b;
	datapathPkg::dwordT z;
	datapathPkg::dwordT result;
	datapathPkg::dwordT rorWide;
	datapathPkg::dwordT rolWide;
	logic signed [63:0] product;
	logic [4:0] shamt;

	assign b = bus.busData;
	assign shamt = b[4:0];	// Shift and rotate counts use only five bits.

	// Rotating a doubled copy avoids a special case for a zero count.
	assign rorWide = {y, y} >> shamt;
	assign rolWide = {y, y} << shamt;

	assign product = $signed({{32{y[31]}}, y}) * $signed({{32{b[31]}}, b});

	always_comb begin
		result = '0;
		if (incPc) begin
			result[31:0] = b + 32'd1;	// PC increment bypasses the opcode.
		end else begin
			case (opcode)
				datapathPkg::opAdd: begin
					result[31:0] = y + b;
				end
				datapathPkg::opSub: begin
					result[31:0] = y - b;
				end
				datapathPkg::opShr: begin
					result[31:0] = y >> shamt;
				end
				datapathPkg::opShra: begin
					result[31:0] = $signed(y) >>> shamt;
				end
				datapathPkg::opShl: begin
					result[31:0] = y << shamt;
				end
				datapathPkg::opRor: begin
					result[31:0] = rorWide[31:0];
				end
				datapathPkg::opRol: begin
					result[31:0] = rolWide[63:32];
				end
				datapathPkg::opAnd: begin
					result[31:0] = y & b;
				end
				datapathPkg::opOr: begin
					result[31:0] = y | b;
				end
				datapathPkg::opMul: begin
					result = product;	// The only result that fills the high half.
				end
				datapathPkg::opNeg: begin
					result[31:0] = -b;
				end
				datapathPkg::opNot: begin
					result[31:0] = ~b;
				end
				default: begin
					result = '0;
				end
			endcase
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			y <= '0;
			z <= '0;
		end else if (clear) begin
			y <= '0;
			z <= '0;
		end else begin
			if (yIn) begin
				y <= b;
			end
			if (zIn) begin
				z <= result;
			end
		end
	end

	assign bus.zHigh = z[63:32];
	assign bus.zLow = z[31:0];

endmodule

// ==== source/busMux.sv ====
`timescale 1ns/1ps

module busMux (
	input logic [15:0] regOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inportOut,
	input logic cOut,
	busIf.mux bus
);

	datapathPkg::busSourceT sel;

	// Strobes are one-hot by contract, so the order here never matters in use.
	always_comb begin
		sel = datapathPkg::srcNone;
		for (int i = 0; i < 16; i++) begin
			if (regOut[i]) begin
				sel = datapathPkg::busSourceT'(int'(datapathPkg::srcReg0) + i);
			end
		end
		if (hiOut) sel = datapathPkg::srcHi;
		if (loOut) sel = datapathPkg::srcLo;
		if (zHighOut) sel = datapathPkg::srcZHigh;
		if (zLowOut) sel = datapathPkg::srcZLow;
		if (pcOut) sel = datapathPkg::srcPc;
		if (mdrOut) sel = datapathPkg::srcMdr;
		if (inportOut) sel = datapathPkg::srcInport;
		if (cOut) sel = datapathPkg::srcC;
	end

	always_comb begin
		case (sel)
			datapathPkg::srcNone: bus.busData = '0;
			datapathPkg::srcHi: bus.busData = bus.hiData;
			datapathPkg::srcLo: bus.busData = bus.loData;
			datapathPkg::srcZHigh: bus.busData = bus.zHigh;
			datapathPkg::srcZLow: bus.busData = bus.zLow;
			datapathPkg::srcPc: bus.busData = bus.pcData;
			datapathPkg::srcMdr: bus.busData = bus.mdrData;
			datapathPkg::srcInport: bus.busData = bus.inportData;
			datapathPkg::srcC: bus.busData = bus.cData;
			default: bus.busData = bus.regData;	// Any of R0 to R15.
		endcase
	end

endmodule

// ==== source/datapath.sv ====
`timescale 1ns/1ps

module datapath (
	input logic Clock,
	input logic rstN,
	input logic clear,
	input logic read,
	input logic incPc,
	input datapathPkg::aluOpT opcode,
	input datapathPkg::wordT memDataIn,
	input datapathPkg::wordT inportIn,
	input logic [15:0] regIn,
	input logic [15:0] regOut,
	input logic hiIn,
	input logic loIn,
	input logic yIn,
	input logic zIn,
	input logic pcIn,
	input logic irIn,
	input logic marIn,
	input logic mdrIn,
	input logic inportLoad,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inportOut,
	input logic cOut,
	output datapathPkg::wordT busOut,
	output datapathPkg::wordT marAddr
);

	busIf dataBus ();

	registerFile regFile (
		.Clock(Clock),
		.rstN(rstN),
		.clear(clear),
		.regIn(regIn),
		.regOut(regOut),
		.bus(dataBus.regs)
	);

	memoryRegs memRegs (
		.Clock(Clock),
		.rstN(rstN),
		.clear(clear),
		.read(read),
		.mdrIn(mdrIn),
		.marIn(marIn),
		.memDataIn(memDataIn),
		.marAddr(marAddr),
		.bus(dataBus.memory)
	);

	specialRegs specRegs (
		.Clock(Clock),
		.rstN(rstN),
		.clear(clear),
		.pcIn(pcIn),
		.irIn(irIn),
		.hiIn(hiIn),
		.loIn(loIn),
		.inportLoad(inportLoad),
		.inportIn(inportIn),
		.bus(dataBus.special)
	);

	alu aluUnit (
		.Clock(Clock),
		.rstN(rstN),
		.clear(clear),
		.yIn(yIn),
		.zIn(zIn),
		.incPc(incPc),
		.opcode(opcode),
		.bus(dataBus.alu)
	);

	busMux mux (
		.regOut(regOut),
		.hiOut(hiOut),
		.loOut(loOut),
		.zHighOut(zHighOut),
		.zLowOut(zLowOut),
		.pcOut(pcOut),
		.mdrOut(mdrOut),
		.inportOut(inportOut),
		.cOut(cOut),
		.bus(dataBus.mux)
	);

	assign busOut = dataBus.busData;

endmodule

// ==== testbench/datapathProperties.sv ====
`timescale 1ns/1ps

module datapathProperties (
	input logic Clock,
	input logic rstN,
	input logic [15:0] regOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inportOut,
	input logic cOut,
	input datapathPkg::wordT busOut,
	input datapathPkg::wordT marAddr
);

	logic [23:0] outStrobes;

	assign outStrobes = {regOut, hiOut, loOut, zHighOut, zLowOut,
		pcOut, mdrOut, inportOut, cOut};

	assert property (@(posedge Clock) disable iff (!rstN) $onehot0(outStrobes))
		else $error("More than one bus source is enabled at once.");

	// Registers come out of reset at zero.
	assert property (@(posedge Clock) $rose(rstN) |-> marAddr == '0)
		else $error("MAR is not zero after reset.");

	assert property (@(posedge Clock) disable iff (!rstN) outStrobes == '0 |-> busOut == '0)
		else $error("The bus is not zero with no source enabled.");

endmodule

bind datapath datapathProperties props (.*);

// ==== testbench/datapathTb.sv ====
`timescale 1ns/1ps

module datapathTb;

	localparam int clockPeriod = 20;
	// Cycles per test in run order: reset, registers, fetch, ALU, clear.
	localparam int testCycles = 4 + 25 + 75 + 10 + 12 * 13 + 26;
	localparam datapathPkg::aluOpT opList [12] = '{datapathPkg::opAdd, datapathPkg::opSub,
		datapathPkg::opShr, datapathPkg::opShra, datapathPkg::opShl, datapathPkg::opRor,
		datapathPkg::opRol, datapathPkg::opAnd, datapathPkg::opOr, datapathPkg::opNeg,
		datapathPkg::opNot, datapathPkg::opMul};

	logic Clock;
	logic rstN;
	logic clear, read, incPc;
	datapathPkg::aluOpT opcode;
	datapathPkg::wordT memDataIn, inportIn;
	logic [15:0] regIn, regOut;
	logic hiIn, loIn, yIn, zIn, pcIn, irIn, marIn, mdrIn, inportLoad;
	logic hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inportOut, cOut;
	datapathPkg::wordT busOut, marAddr;
	integer seed = 38903;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;

	datapath DUT (.*);

	initial begin
		Clock = 1'b0;
		forever #(clockPeriod / 2) Clock = ~Clock;
	end

	initial begin
		#(2 * testCycles * clockPeriod);	// Twice the expected run time.
		$display("Timeout: the tests did not finish within %0d cycles.", 2 * testCycles);
		$display("TESTS FAILED");
		$finish;
	end

	// A step starts at a rising edge with every strobe dropped.
	task automatic nextCycle();
		@(posedge Clock);
		{clear, read, incPc, regIn, regOut} <= '0;
		{hiIn, loIn, yIn, zIn, pcIn, irIn, marIn, mdrIn, inportLoad} <= '0;
		{hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inportOut, cOut} <= '0;
	endtask

	task automatic check(string testName, datapathPkg::wordT expected,
			datapathPkg::wordT actual);
		checkCount++;
		assert (actual === expected) else begin
			$display("** Error %s: expected %h, actual %h", testName, expected, actual);
			errorCount++;
		end
	endtask

	task automatic readBus(string testName, datapathPkg::wordT expected);
		@(negedge Clock);	// The bus has settled by the falling edge.
		check(testName, expected, busOut);
	endtask

	task automatic finishTest(string testName, int errorsBefore);
		testCount++;
		$display("%s test done with %0d errors", testName, errorCount - errorsBefore);
	endtask

	// Memory data goes into MDR, then MDR drives the bus for the next load.
	task automatic loadMdr(datapathPkg::wordT value);
		nextCycle();
		memDataIn <= value;
		read <= 1'b1;
		mdrIn <= 1'b1;
		nextCycle();
		mdrOut <= 1'b1;
	endtask

	// Targets 0 to 15 are R0 to R15, 16 is HI and 17 is LO.
	task automatic loadReg(int target, datapathPkg::wordT value);
		loadMdr(value);
		{loIn, hiIn, regIn} <= 18'b1 << target;
	endtask

	function automatic datapathPkg::wordT expectedLow(datapathPkg::aluOpT op,
			datapathPkg::wordT a, datapathPkg::wordT b);
		logic [4:0] s;
		s = b[4:0];
		case (op)
			datapathPkg::opAdd: return a + b;
			datapathPkg::opSub: return a - b;
			datapathPkg::opShr: return a >> s;
			datapathPkg::opShra: return (a >> s) | (a[31] ? ~(32'hffffffff >> s) : 32'h0);
			datapathPkg::opShl: return a << s;
			datapathPkg::opRor: return (s == 5'd0) ? a : (a >> s) | (a << (32 - s));
			datapathPkg::opRol: return (s == 5'd0) ? a : (a << s) | (a >> (32 - s));
			datapathPkg::opAnd: return a & b;
			datapathPkg::opOr: return a | b;
			datapathPkg::opNeg: return ~b + 32'd1;
			datapathPkg::opNot: return ~b;
			default: return '0;
		endcase
	endfunction

	// Operands go to R2 and R3. Y takes R2, then Z takes the result with R3 on the bus.
	task automatic runAlu(datapathPkg::aluOpT op, datapathPkg::wordT a, datapathPkg::wordT b);
		loadReg(2, a);
		loadReg(3, b);
		nextCycle();
		regOut <= 16'b1 << 2;
		yIn <= 1'b1;
		nextCycle();
		regOut <= 16'b1 << 3;
		opcode <= op;
		zIn <= 1'b1;
	endtask

	// Every bus source and MAR must read zero.
	task automatic zeroTest(string testName, logic pulseClear);
		int errorsBefore = errorCount;
		if (pulseClear) begin
			nextCycle();
			clear <= 1'b1;
		end
		for (int i = 0; i < 24; i++) begin
			nextCycle();
			{regOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inportOut, cOut}
				<= 24'b1 << i;
			readBus(testName, '0);
		end
		check(testName, '0, marAddr);
		finishTest(testName, errorsBefore);
	endtask

	task automatic registerTest();
		int errorsBefore = errorCount;
		datapathPkg::wordT values [19];
		for (int i = 0; i < 19; i++) begin
			values[i] = $random(seed);
		end
		for (int i = 0; i < 18; i++) begin
			loadReg(i, values[i]);
		end
		nextCycle();
		inportIn <= values[18];
		inportLoad <= 1'b1;
		for (int i = 0; i < 18; i++) begin
			nextCycle();
			{loOut, hiOut, regOut} <= 18'b1 << i;
			readBus("registers", values[i]);
		end
		nextCycle();
		inportOut <= 1'b1;
		readBus("registers", values[18]);
		finishTest("registers", errorsBefore);
	endtask

	// Z moves through HI and LO so the product also round-trips.
	task automatic aluTest();
		int errorsBefore = errorCount;
		datapathPkg::wordT a;
		datapathPkg::wordT b;
		logic signed [63:0] product;
		datapathPkg::dwordT expected;
		string name;
		for (int k = 0; k < 12; k++) begin
			a = $random(seed);
			b = $random(seed);
			if (opList[k] == datapathPkg::opShra) begin
				a[31] = 1'b1;	// Shifting a negative number must keep its sign.
			end
			product = longint'($signed(a)) * longint'($signed(b));
			expected = (opList[k] == datapathPkg::opMul) ? product
				: {32'b0, expectedLow(opList[k], a, b)};
			name = $sformatf("alu op %0d", opList[k]);
			runAlu(opList[k], a, b);
			nextCycle();
			zHighOut <= 1'b1;
			hiIn <= 1'b1;
			readBus(name, expected[63:32]);
			nextCycle();
			zLowOut <= 1'b1;
			loIn <= 1'b1;
			readBus(name, expected[31:0]);
			nextCycle();
			hiOut <= 1'b1;
			readBus(name, expected[63:32]);
			nextCycle();
			loOut <= 1'b1;
			readBus(name, expected[31:0]);
		end
		finishTest("alu", errorsBefore);
	endtask

	task automatic fetchTest();
		int errorsBefore = errorCount;
		datapathPkg::wordT pcStart;
		datapathPkg::wordT instr;
		pcStart = $random(seed);
		instr = $random(seed);
		instr[18] = 1'b1;	// Negative constant, so the sign extension shows.
		loadMdr(pcStart);
		pcIn <= 1'b1;
		nextCycle();
		{pcOut, marIn, incPc, zIn} <= 4'hf;
		nextCycle();
		{zLowOut, pcIn} <= 2'b11;
		@(negedge Clock);
		check("fetch", pcStart, marAddr);
		nextCycle();
		memDataIn <= instr;
		{read, mdrIn, pcOut} <= 3'b111;
		readBus("fetch", pcStart + 32'd1);
		nextCycle();
		{mdrOut, irIn} <= 2'b11;
		nextCycle();
		cOut <= 1'b1;
		readBus("fetch", {{13{instr[18]}}, instr[18:0]});
		finishTest("fetch", errorsBefore);
	endtask

	initial begin
		rstN <= 1'b0;
		opcode <= datapathPkg::opAdd;
		memDataIn <= '0;
		inportIn <= '0;
		{clear, read, incPc, regIn, regOut} <= '0;
		{hiIn, loIn, yIn, zIn, pcIn, irIn, marIn, mdrIn, inportLoad} <= '0;
		{hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inportOut, cOut} <= '0;
		repeat (4) @(posedge Clock);
		rstN <= 1'b1;
		zeroTest("reset", 1'b0);
		registerTest();
		fetchTest();
		aluTest();
		zeroTest("clear", 1'b1);
		$display("%0d tests run, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
source/datapathPkg.sv
source/busIf.sv
source/registerFile.sv
source/memoryRegs.sv
source/specialRegs.sv
source/alu.sv
source/busMux.sv
source/datapath.sv
testbench/datapathProperties.sv
testbench/datapathTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module datapathTb -o datapathSim \
	&& ./obj_dir/datapathSim | tee /dev/stderr | grep -q "TESTS PASSED" \
	&& echo "Simulation run succeeded" || { echo "Simulation run did not succeed"; exit 1; }
